//--- verilog/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

`define L2_ADDR_BITS	16	// word address
`define L2_DATA_BITS	32	// one word per line
`define L2_INDEX_BITS	4	// 16 sets
`define L2_WAY_BITS	1	// two ways
`define L2_ID_BITS	3	// core request id
`define L2_MSHR_BITS	2	// four miss entries

// sizes that follow from the ones above
`define L2_TAG_BITS	(`L2_ADDR_BITS - `L2_INDEX_BITS)
`define L2_SETS	(1 << `L2_INDEX_BITS)
`define L2_WAYS	(1 << `L2_WAY_BITS)
`define L2_MSHR_DEPTH	(1 << `L2_MSHR_BITS)

`endif

//--- verilog/cache_pkg.sv
`include "cache_settings.svh"

package cache_pkg;

	typedef logic [`L2_ADDR_BITS-1:0] addr_t;
	typedef logic [`L2_DATA_BITS-1:0] data_t;
	typedef logic [`L2_INDEX_BITS-1:0] index_t;
	typedef logic [`L2_TAG_BITS-1:0] tag_t;
	typedef logic [`L2_WAY_BITS-1:0] way_t;
	typedef logic [`L2_ID_BITS-1:0] id_t;

	typedef struct packed {
		addr_t addr;
		data_t data;
		logic we;
		id_t id;
	} core_req_t;

	typedef struct packed {
		data_t data;
		id_t id;
	} core_rsp_t;

	typedef struct packed {
		addr_t addr;
		data_t data;
		logic we;
		id_t id;
		way_t way;	// victim way picked at push
	} miss_entry_t;

	typedef struct packed {
		index_t index;
		way_t way;
		tag_t tag;
		data_t data;
		logic dirty;
	} fill_t;

	typedef struct packed {
		tag_t tag;
		logic valid;
		logic dirty;
	} victim_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		addr_t adr;
		data_t dat;
	} wb_m2s_t;

	typedef struct packed {
		logic ack;
		data_t dat;
	} wb_s2m_t;

	typedef enum logic [1:0] {
		st_idle,
		st_evict,
		st_fetch,
		st_fill
	} refill_state_e;

endpackage

//--- verilog/tag_data_array.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module tag_data_array (
	input logic clk,
	input logic reset,

	input cache_pkg::index_t lookup_index_i,
	input cache_pkg::tag_t lookup_tag_i,
	output logic hit_o,
	output cache_pkg::way_t hit_way_o,
	output cache_pkg::data_t hit_data_o,
	output logic hit_dirty_o,

	input logic write_valid_i,	// write hit from the core side
	input cache_pkg::way_t write_way_i,
	input cache_pkg::data_t write_data_i,

	input cache_pkg::index_t victim_index_i,
	input cache_pkg::way_t victim_way_i,
	output cache_pkg::victim_t victim_o,
	output cache_pkg::data_t victim_data_o,

	input logic fill_valid_i,
	input cache_pkg::fill_t fill_i
);

	cache_pkg::tag_t tag_mem [`L2_WAYS][`L2_SETS];
	cache_pkg::data_t data_mem [`L2_WAYS][`L2_SETS];
	logic [`L2_SETS-1:0] valid_q [`L2_WAYS];
	logic [`L2_SETS-1:0] dirty_q [`L2_WAYS];

	// compare the tag in every way of the set
	always_comb begin
		hit_o = 1'b0;
		hit_way_o = '0;
		for (int w = 0; w < `L2_WAYS; w++) begin
			if (valid_q[w][lookup_index_i] && (tag_mem[w][lookup_index_i] == lookup_tag_i)) begin
				hit_o = 1'b1;
				hit_way_o = cache_pkg::way_t'(w);
			end
		end
	end

	assign hit_data_o = data_mem[hit_way_o][lookup_index_i];
	assign hit_dirty_o = dirty_q[hit_way_o][lookup_index_i];	// only meaningful on a hit

	// second read port for the refill side
	assign victim_o = '{
		tag: tag_mem[victim_way_i][victim_index_i],
		valid: valid_q[victim_way_i][victim_index_i],
		dirty: dirty_q[victim_way_i][victim_index_i]
	};
	assign victim_data_o = data_mem[victim_way_i][victim_index_i];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			for (int w = 0; w < `L2_WAYS; w++) begin
				valid_q[w] <= '0;
				dirty_q[w] <= '0;
			end
		end else if (fill_valid_i) begin
			valid_q[fill_i.way][fill_i.index] <= 1'b1;
			dirty_q[fill_i.way][fill_i.index] <= fill_i.dirty;
		end else if (write_valid_i) begin
			dirty_q[write_way_i][lookup_index_i] <= 1'b1;	// line now differs from memory
		end
	end

	always_ff @(posedge clk) begin
		if (fill_valid_i) begin
			tag_mem[fill_i.way][fill_i.index] <= fill_i.tag;
			data_mem[fill_i.way][fill_i.index] <= fill_i.data;
		end else if (write_valid_i) begin
			data_mem[write_way_i][lookup_index_i] <= write_data_i;
		end
	end

endmodule

//--- verilog/request_stage.sv
`timescale 1ns/100ps

module request_stage (
	input logic clk,
	input logic reset,

	input logic req_valid_i,
	input cache_pkg::core_req_t req_i,
	output logic stall_o,
	output logic rsp_valid_o,
	output cache_pkg::core_rsp_t rsp_o,

	input logic hit_i,
	input cache_pkg::data_t hit_data_i,
	output logic write_valid_o,

	output logic miss_push_o,
	output cache_pkg::miss_entry_t miss_o,
	input logic mq_full_i,
	input logic mq_conflict_i,

	input logic fill_valid_i,
	input cache_pkg::data_t fill_data_i,
	input cache_pkg::id_t fill_id_i,
	input logic fill_we_i
);

	logic accept;
	logic read_hit;
	logic fill_read;
	cache_pkg::way_t rr_way;

	// array port is taken by the refill on a fill cycle
	assign stall_o = mq_full_i | fill_valid_i | (req_valid_i & mq_conflict_i);
	assign accept = req_valid_i & ~stall_o;

	assign read_hit = accept & hit_i & ~req_i.we;
	assign fill_read = fill_valid_i & ~fill_we_i;
	assign write_valid_o = accept & hit_i & req_i.we;
	assign miss_push_o = accept & ~hit_i;

	assign miss_o = '{
		addr: req_i.addr,
		data: req_i.data,
		we: req_i.we,
		id: req_i.id,
		way: rr_way
	};

	// round robin victim pointer
	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rr_way <= '0;
		end else if (miss_push_o) begin
			rr_way <= rr_way + 1'b1;
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			rsp_valid_o <= 1'b0;
		end else begin
			rsp_valid_o <= read_hit | fill_read;
		end
	end

	// hit and fill never meet, the fill cycle stalls the core
	always_ff @(posedge clk) begin
		if (fill_read) begin
			rsp_o <= '{data: fill_data_i, id: fill_id_i};
		end else if (read_hit) begin
			rsp_o <= '{data: hit_data_i, id: req_i.id};
		end
	end

endmodule

//--- verilog/miss_queue.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module miss_queue (
	input logic clk,
	input logic reset,

	input logic push_i,
	input cache_pkg::miss_entry_t entry_i,

	input cache_pkg::index_t check_index_i,
	output logic full_o,
	output logic conflict_o,

	output logic head_valid_o,
	output cache_pkg::miss_entry_t head_o,
	input logic retire_i	// pops the head
);

	cache_pkg::miss_entry_t entry_q [`L2_MSHR_DEPTH];
	logic [`L2_MSHR_DEPTH-1:0] valid_q;
	logic [`L2_MSHR_BITS-1:0] head_q;
	logic [`L2_MSHR_BITS-1:0] tail_q;

	// slot under tail still busy means every slot is busy
	assign full_o = valid_q[tail_q];
	assign head_valid_o = valid_q[head_q];
	assign head_o = entry_q[head_q];

	// one pending miss per set at a time
	always_comb begin
		conflict_o = 1'b0;
		for (int i = 0; i < `L2_MSHR_DEPTH; i++) begin
			if (valid_q[i] && (entry_q[i].addr[`L2_INDEX_BITS-1:0] == check_index_i)) begin
				conflict_o = 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= '0;
			head_q <= '0;
			tail_q <= '0;
		end else begin
			if (push_i) begin
				valid_q[tail_q] <= 1'b1;
				tail_q <= tail_q + 1'b1;
			end
			if (retire_i) begin
				valid_q[head_q] <= 1'b0;	// never the tail slot
				head_q <= head_q + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push_i) begin
			entry_q[tail_q] <= entry_i;
		end
	end

endmodule

//--- verilog/refill_fsm.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module refill_fsm (
	input logic clk,
	input logic reset,

	input logic head_valid_i,
	input cache_pkg::miss_entry_t head_i,
	output logic retire_o,

	output cache_pkg::index_t victim_index_o,
	output cache_pkg::way_t victim_way_o,
	input cache_pkg::victim_t victim_i,
	input cache_pkg::data_t victim_data_i,

	output logic fill_valid_o,
	output cache_pkg::fill_t fill_o,
	output logic fill_we_o,
	output cache_pkg::id_t fill_id_o,
	output cache_pkg::data_t fill_data_o,

	output cache_pkg::wb_m2s_t wb_o,
	input cache_pkg::wb_s2m_t wb_i
);

	cache_pkg::refill_state_e state_q;
	logic cyc_q;
	logic we_q;
	cache_pkg::addr_t adr_q;
	cache_pkg::data_t dat_q;
	cache_pkg::data_t fetch_q;	// word returned by the fetch
	cache_pkg::index_t head_index;
	cache_pkg::tag_t head_tag;
	logic victim_dirty;
	logic done;

	assign head_index = head_i.addr[`L2_INDEX_BITS-1:0];
	assign head_tag = head_i.addr[`L2_ADDR_BITS-1:`L2_INDEX_BITS];

	// the set stays untouched while its miss is pending
	assign victim_index_o = head_index;
	assign victim_way_o = head_i.way;
	assign victim_dirty = victim_i.valid & victim_i.dirty;

	assign done = cyc_q & wb_i.ack;
	assign wb_o = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, dat: dat_q};

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state_q <= cache_pkg::st_idle;
			cyc_q <= 1'b0;
		end else begin
			case (state_q)
				cache_pkg::st_idle: begin
					if (head_valid_i) begin
						state_q <= victim_dirty ? cache_pkg::st_evict : cache_pkg::st_fetch;
					end
				end
				cache_pkg::st_evict: begin
					if (!cyc_q) begin
						cyc_q <= 1'b1;
					end else if (wb_i.ack) begin
						cyc_q <= 1'b0;	// bus idles a cycle before the fetch
						state_q <= cache_pkg::st_fetch;
					end
				end
				cache_pkg::st_fetch: begin
					if (!cyc_q) begin
						cyc_q <= 1'b1;
					end else if (wb_i.ack) begin
						cyc_q <= 1'b0;
						state_q <= cache_pkg::st_fill;
					end
				end
				default: begin
					state_q <= cache_pkg::st_idle;	// fill lasts one cycle
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state_q == cache_pkg::st_evict && !cyc_q) begin
			we_q <= 1'b1;
			adr_q <= {victim_i.tag, head_index};	// old line address
			dat_q <= victim_data_i;
		end else if (state_q == cache_pkg::st_fetch && !cyc_q) begin
			we_q <= 1'b0;
			adr_q <= head_i.addr;
		end
		if (state_q == cache_pkg::st_fetch && done) begin
			fetch_q <= wb_i.dat;
		end
	end

	assign fill_valid_o = (state_q == cache_pkg::st_fill);
	assign retire_o = fill_valid_o;
	assign fill_we_o = head_i.we;
	assign fill_id_o = head_i.id;
	assign fill_data_o = head_i.we ? head_i.data : fetch_q;	// write data replaces whole line

	assign fill_o = '{
		index: head_index,
		way: head_i.way,
		tag: head_tag,
		data: fill_data_o,
		dirty: head_i.we
	};

endmodule

//--- verilog/l2_cache.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module l2_cache (
	input logic clk,
	input logic reset,

	input logic req_valid_i,
	input cache_pkg::core_req_t req_i,
	output logic stall_o,
	output logic rsp_valid_o,
	output cache_pkg::core_rsp_t rsp_o,

	output cache_pkg::wb_m2s_t wb_o,
	input cache_pkg::wb_s2m_t wb_i
);

	logic hit;
	cache_pkg::way_t hit_way;
	cache_pkg::data_t hit_data;
	logic write_valid;

	logic miss_push;
	cache_pkg::miss_entry_t miss_entry;
	logic mq_full;
	logic mq_conflict;
	logic head_valid;
	cache_pkg::miss_entry_t head_entry;
	logic retire;

	cache_pkg::index_t victim_index;
	cache_pkg::way_t victim_way;
	cache_pkg::victim_t victim;
	cache_pkg::data_t victim_data;

	logic fill_valid;
	cache_pkg::fill_t fill;
	logic fill_we;
	cache_pkg::id_t fill_id;
	cache_pkg::data_t fill_data;

	tag_data_array array_i (
		.clk(clk),
		.reset(reset),
		.lookup_index_i(req_i.addr[`L2_INDEX_BITS-1:0]),
		.lookup_tag_i(req_i.addr[`L2_ADDR_BITS-1:`L2_INDEX_BITS]),
		.hit_o(hit),
		.hit_way_o(hit_way),
		.hit_data_o(hit_data),
		.hit_dirty_o(),
		.write_valid_i(write_valid),
		.write_way_i(hit_way),	// write hits go to the matching way
		.write_data_i(req_i.data),
		.victim_index_i(victim_index),
		.victim_way_i(victim_way),
		.victim_o(victim),
		.victim_data_o(victim_data),
		.fill_valid_i(fill_valid),
		.fill_i(fill)
	);

	request_stage req_stage_i (
		.clk(clk),
		.reset(reset),
		.req_valid_i(req_valid_i),
		.req_i(req_i),
		.stall_o(stall_o),
		.rsp_valid_o(rsp_valid_o),
		.rsp_o(rsp_o),
		.hit_i(hit),
		.hit_data_i(hit_data),
		.write_valid_o(write_valid),
		.miss_push_o(miss_push),
		.miss_o(miss_entry),
		.mq_full_i(mq_full),
		.mq_conflict_i(mq_conflict),
		.fill_valid_i(fill_valid),
		.fill_data_i(fill_data),
		.fill_id_i(fill_id),
		.fill_we_i(fill_we)
	);

	miss_queue mq_i (
		.clk(clk),
		.reset(reset),
		.push_i(miss_push),
		.entry_i(miss_entry),
		.check_index_i(req_i.addr[`L2_INDEX_BITS-1:0]),
		.full_o(mq_full),
		.conflict_o(mq_conflict),
		.head_valid_o(head_valid),
		.head_o(head_entry),
		.retire_i(retire)
	);

	refill_fsm refill_i (
		.clk(clk),
		.reset(reset),
		.head_valid_i(head_valid),
		.head_i(head_entry),
		.retire_o(retire),
		.victim_index_o(victim_index),
		.victim_way_o(victim_way),
		.victim_i(victim),
		.victim_data_i(victim_data),
		.fill_valid_o(fill_valid),
		.fill_o(fill),
		.fill_we_o(fill_we),
		.fill_id_o(fill_id),
		.fill_data_o(fill_data),
		.wb_o(wb_o),
		.wb_i(wb_i)
	);

endmodule

//--- testbench/wb_memory_model.sv
`timescale 1ns/100ps
`include "cache_settings.svh"

module wb_memory_model (
	input logic clk,
	input logic reset,
	input cache_pkg::wb_m2s_t wb_i,
	output cache_pkg::wb_s2m_t wb_o
);

	cache_pkg::data_t mem [1 << `L2_ADDR_BITS];
	logic busy;
	logic [1:0] wait_cnt;	// cycles left before ack
	logic ack;
	cache_pkg::data_t rdata;

	initial begin
		void'($urandom(32'h88d4));
		for (int a = 0; a < (1 << `L2_ADDR_BITS); a++) begin
			mem[a] = 32'(a) ^ 32'h5a5a_0000;
		end
	end

	assign wb_o = '{ack: ack, dat: rdata};

	always @(posedge clk or negedge reset) begin
		if (!reset) begin
			ack <= 1'b0;
			busy <= 1'b0;
			wait_cnt <= '0;
		end else begin
			ack <= 1'b0;	// single cycle ack
			if (wb_i.cyc && wb_i.stb && !ack) begin
				if (!busy) begin
					busy <= 1'b1;
					wait_cnt <= 2'($urandom % 4);	// 1 to 4 cycles
				end else if (wait_cnt != 2'd0) begin
					wait_cnt <= wait_cnt - 2'd1;
				end else begin
					busy <= 1'b0;
					ack <= 1'b1;
					if (wb_i.we) begin
						mem[wb_i.adr] = wb_i.dat;
					end else begin
						rdata <= mem[wb_i.adr];
					end
				end
			end
		end
	end

endmodule

//--- testbench/l2_cache_tb.sv
`timescale 1ns/100ps

module l2_cache_tb;

	localparam int timeout_cycles = 200;
	localparam logic [3:0] flag_sync = 4'b0001;	// wait for every open read
	localparam logic [3:0] flag_stall = 4'b0010;	// must be held by stall_o first
	localparam logic [3:0] flag_fast = 4'b0100;	// hit, answered one cycle after acceptance
	localparam logic [3:0] flag_early = 4'b1000;	// answered while an older miss is open

	typedef struct packed {
		cache_pkg::core_req_t req;
		logic expect_rsp;
		cache_pkg::data_t exp_data;
		logic [3:0] flags;
	} row_t;

	logic clk;
	logic reset;
	logic req_valid;
	cache_pkg::core_req_t req;
	logic stall;
	logic rsp_valid;
	cache_pkg::core_rsp_t rsp;
	cache_pkg::wb_m2s_t wb_m2s;
	cache_pkg::wb_s2m_t wb_s2m;

	row_t rows[$];
	string row_names[$];
	bit row_bad[$];
	int pend_idx[$];	// rows still waiting for a response
	int pend_cycle[$];
	cache_pkg::core_rsp_t rsp_q[$];
	int rsp_cycle_q[$];
	int cycle = 0;
	int pass_count;
	int fail_count;
	int error_count;
	bit aborted;

	l2_cache dut_i (
		.clk(clk),
		.reset(reset),
		.req_valid_i(req_valid),
		.req_i(req),
		.stall_o(stall),
		.rsp_valid_o(rsp_valid),
		.rsp_o(rsp),
		.wb_o(wb_m2s),
		.wb_i(wb_s2m)
	);

	wb_memory_model mem_i (
		.clk(clk),
		.reset(reset),
		.wb_i(wb_m2s),
		.wb_o(wb_s2m)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	// responses are registered, so they are stable at the falling edge
	always @(negedge clk) begin
		if (rsp_valid) begin
			rsp_q.push_back(rsp);
			rsp_cycle_q.push_back(cycle);
		end
	end

	function automatic cache_pkg::data_t memory_pattern(input cache_pkg::addr_t addr);
		return {16'h0000, addr} ^ 32'h5a5a_0000;
	endfunction

	task automatic check_data(input string name, input cache_pkg::data_t expected,
			input cache_pkg::data_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: data expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_id(input string name, input cache_pkg::id_t expected,
			input cache_pkg::id_t actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: id expected %0d, actual %0d", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic report_line(input string name, input bit ok);
		if (ok) begin
			$display("PASS %s", name);
			pass_count++;
		end else begin
			$display("FAIL %s", name);
			fail_count++;
		end
	endtask

	task automatic add_row(input string name, input cache_pkg::addr_t addr,
			input cache_pkg::data_t data, input logic we, input cache_pkg::id_t id,
			input cache_pkg::data_t exp_data, input logic [3:0] flags);
		row_t row;
		row.req = '{addr: addr, data: data, we: we, id: id};
		row.expect_rsp = ~we;	// writes complete silently
		row.exp_data = exp_data;
		row.flags = flags;
		rows.push_back(row);
		row_names.push_back(name);
		row_bad.push_back(1'b0);
	endtask

	task automatic build_table();
		add_row("read_miss", 16'h0010, '0, 1'b0, 3'd1, memory_pattern(16'h0010), flag_sync);
		add_row("read_hit", 16'h0010, '0, 1'b0, 3'd2, memory_pattern(16'h0010),
			flag_sync | flag_fast);
		add_row("write_hit", 16'h0010, 32'hcafe_0001, 1'b1, 3'd3, '0, '0);
		add_row("read_after_write_hit", 16'h0010, '0, 1'b0, 3'd4, 32'hcafe_0001,
			flag_sync | flag_fast);
		add_row("write_miss", 16'h0123, 32'h1234_5678, 1'b1, 3'd5, '0, '0);
		add_row("read_after_write_miss", 16'h0123, '0, 1'b0, 3'd6, 32'h1234_5678, flag_sync);
		// three tags in set 5, two ways, so dirty lines get evicted
		add_row("dirty_write_a", 16'h0105, 32'haaaa_0105, 1'b1, 3'd0, '0, '0);
		add_row("dirty_write_b", 16'h0205, 32'hbbbb_0205, 1'b1, 3'd1, '0, '0);
		add_row("dirty_write_c", 16'h0305, 32'hcccc_0305, 1'b1, 3'd2, '0, '0);
		add_row("read_back_a", 16'h0105, '0, 1'b0, 3'd3, 32'haaaa_0105, flag_sync);
		add_row("read_back_b", 16'h0205, '0, 1'b0, 3'd4, 32'hbbbb_0205, flag_sync);
		add_row("read_back_c", 16'h0305, '0, 1'b0, 3'd5, 32'hcccc_0305, flag_sync);
		add_row("miss_behind_hit", 16'h0aa7, '0, 1'b0, 3'd6, memory_pattern(16'h0aa7), '0);
		add_row("hit_under_miss", 16'h0010, '0, 1'b0, 3'd7, 32'hcafe_0001,
			flag_sync | flag_fast | flag_early);
		add_row("miss_set_8", 16'h0b08, '0, 1'b0, 3'd0, memory_pattern(16'h0b08), '0);
		add_row("miss_set_9", 16'h0b09, '0, 1'b0, 3'd1, memory_pattern(16'h0b09), '0);
		add_row("miss_set_a", 16'h0b0a, '0, 1'b0, 3'd2, memory_pattern(16'h0b0a), '0);
		add_row("miss_set_b", 16'h0b0b, '0, 1'b0, 3'd3, memory_pattern(16'h0b0b), '0);
		// set b retires last, so its conflict outlasts the full queue
		add_row("conflict_set_b", 16'h0c0b, '0, 1'b0, 3'd4, memory_pattern(16'h0c0b),
			flag_sync | flag_stall);
	endtask

	task automatic match_responses();
		cache_pkg::core_rsp_t r;
		int c;
		int k;
		int idx;
		int errs;
		while (rsp_q.size() > 0) begin
			r = rsp_q.pop_front();
			c = rsp_cycle_q.pop_front();
			k = -1;
			// a hit owns the response of the cycle after its acceptance
			for (int j = 0; j < pend_idx.size(); j++) begin
				if ((rows[pend_idx[j]].flags & flag_fast) != 0 && pend_cycle[j] == c) k = j;
			end
			for (int j = 0; j < pend_idx.size() && k < 0; j++) begin
				if (rows[pend_idx[j]].req.id == r.id) k = j;
			end
			if (k < 0) begin
				$display("A response with id %0d matched no open read.", r.id);
				error_count++;
			end else begin
				idx = pend_idx[k];
				errs = error_count;
				check_id(row_names[idx], rows[idx].req.id, r.id);
				check_data(row_names[idx], rows[idx].exp_data, r.data);
				if ((rows[idx].flags & flag_fast) != 0 && c != pend_cycle[k]) begin
					$display("%s was not answered one cycle after acceptance.", row_names[idx]);
					error_count++;
				end
				if ((rows[idx].flags & flag_early) != 0 && pend_idx.size() < 2) begin
					$display("%s was not answered before the older miss.", row_names[idx]);
					error_count++;
				end
				report_line(row_names[idx], errs == error_count && !row_bad[idx]);
				pend_idx.delete(k);
				pend_cycle.delete(k);
			end
		end
	endtask

	task automatic wait_all();
		int tries;
		tries = 0;
		while (pend_idx.size() > 0 && tries < timeout_cycles) begin
			#10;
			match_responses();
			@(negedge clk);
			tries++;
		end
		if (pend_idx.size() > 0) begin
			$display("%0d reads got no response before the timeout.", pend_idx.size());
			foreach (pend_idx[j]) report_line(row_names[pend_idx[j]], 1'b0);
			aborted = 1'b1;
		end
	endtask

	// starts and ends on a falling edge
	task automatic apply_row(input int i);
		int tries;
		int accept_cycle;
		cache_pkg::index_t set_idx;
		tries = 0;
		accept_cycle = 0;
		set_idx = cache_pkg::index_t'(rows[i].req.addr);
		req_valid = 1'b1;
		req = rows[i].req;
		#10;
		match_responses();
		while (stall && tries < timeout_cycles) begin
			tries++;
			@(negedge clk);
			#10;
			match_responses();
		end
		if (stall) begin
			$display("Request %s was never accepted before the timeout.", row_names[i]);
			report_line(row_names[i], 1'b0);
			aborted = 1'b1;
		end else begin
			accept_cycle = cycle + 1;	// taken on the coming rising edge
			if ((rows[i].flags & flag_stall) != 0 && tries == 0) begin
				$display("%s was accepted without being held by stall_o.", row_names[i]);
				error_count++;
				row_bad[i] = 1'b1;
			end
			if ((rows[i].flags & flag_stall) != 0) begin
				foreach (pend_idx[j]) begin
					if (cache_pkg::index_t'(rows[pend_idx[j]].req.addr) == set_idx) begin
						$display("%s was accepted while a miss to its set was open.",
							row_names[i]);
						error_count++;
						row_bad[i] = 1'b1;
					end
				end
			end
		end
		@(negedge clk);
		req_valid = 1'b0;
		if (!aborted) begin
			if (rows[i].expect_rsp) begin
				pend_idx.push_back(i);
				pend_cycle.push_back(accept_cycle);
			end else begin
				report_line(row_names[i], !row_bad[i]);
			end
			if ((rows[i].flags & flag_sync) != 0) wait_all();
		end
	endtask

	initial begin
		req_valid = 1'b0;
		req = '0;
		reset = 1'b0;
		pass_count = 0;
		fail_count = 0;
		error_count = 0;
		aborted = 1'b0;
		build_table();
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b1;
		#10;
		if (rsp_valid !== 1'b0 || stall !== 1'b0 || wb_m2s.cyc !== 1'b0
				|| wb_m2s.stb !== 1'b0) begin
			$display("Outputs were not idle after reset.");
			error_count++;
			report_line("reset_state", 1'b0);
		end else begin
			report_line("reset_state", 1'b1);
		end
		@(negedge clk);
		for (int i = 0; i < rows.size(); i++) begin
			if (!aborted) apply_row(i);
		end
		if (!aborted) wait_all();
		$display("%0d tests passed, %0d tests failed, %0d check errors",
			pass_count, fail_count, error_count);
		if (!aborted && fail_count == 0 && error_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
+incdir+verilog
verilog/cache_pkg.sv
verilog/tag_data_array.sv
verilog/request_stage.sv
verilog/miss_queue.sv
verilog/refill_fsm.sv
verilog/l2_cache.sv
testbench/wb_memory_model.sv
testbench/l2_cache_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       ?= l2_cache_tb
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
